/* hw/capture_macros.svh */
`ifndef CAPTURE_MACROS_SVH
`define CAPTURE_MACROS_SVH

// width of one ADC sample
`define CAP_SAMPLE_W 12

// sample FIFO geometry, depth must be 2**AW
`define CAP_FIFO_DEPTH 64
`define CAP_FIFO_AW 6

// offset and length counters
`define CAP_CNT_W 16

`endif

/* hw/capture_pkg.sv */
`include "capture_macros.svh"

package capture_pkg;

   typedef logic [`CAP_SAMPLE_W-1:0] sample_t;   // raw unsigned ADC code
   typedef logic [`CAP_CNT_W-1:0]    count_t;    // offset or length in cycles

   // trigger source used by the sequencer
   typedef enum logic {
      TRIG_EXT = 1'b0,   // external trigger pin
      TRIG_ADC = 1'b1    // ADC level compare
   } trig_src_e;

   // host configuration, held stable while armed
   typedef struct packed {
      logic      test_pattern;   // counter instead of ADC pins
      trig_src_e trig_src;
      logic      trig_high;      // external trigger active high
      logic      trig_wait;      // see trigger inactive before arming
      sample_t   adc_level;      // msb set: fire above, clear: fire below
      count_t    offset;         // cycles skipped after the trigger
      count_t    length;         // samples written, at least 1
   } capture_cfg_t;

   // capture status seen by the host
   typedef struct packed {
      logic armed;
      logic capture_active;
      logic capture_done;
      logic overflow;
      logic adc_trigger;
   } capture_status_t;

endpackage

/* hw/adc_sample_source.sv */
`timescale 1ns/1ps

module adc_sample_source (
   input  logic                      ADC_clk_sample,
   input  logic                      reset,
   input  capture_pkg::capture_cfg_t cfg_i,
   input  capture_pkg::sample_t      adc_data_i,
   output capture_pkg::sample_t      sample_o
);
   import capture_pkg::*;

   sample_t test_cnt;   // free-running ramp for test mode

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         test_cnt <= '0;
      end else begin
         test_cnt <= test_cnt + 1'b1;   // wraps at 4096
      end
   end

   // one register stage between pins and the rest of the front end
   always_ff @(posedge ADC_clk_sample) begin
      if (cfg_i.test_pattern) begin
         sample_o <= test_cnt;
      end else begin
         sample_o <= adc_data_i;
      end
   end

endmodule

/* hw/adc_level_trigger.sv */
`timescale 1ns/1ps
`include "capture_macros.svh"

module adc_level_trigger (
   input  logic                      ADC_clk_sample,
   input  logic                      reset,
   input  capture_pkg::capture_cfg_t cfg_i,
   input  capture_pkg::sample_t      sample_i,
   input  logic                      arm_pulse_i,
   output logic                      adc_trig_o
);

   logic allow;       // one trigger allowed per arm pulse
   logic above_sel;   // level msb picks the compare direction
   logic crossed;
   logic hit;

   assign above_sel = cfg_i.adc_level[`CAP_SAMPLE_W-1];

   always_comb begin
      if (above_sel) begin
         crossed = sample_i > cfg_i.adc_level;
      end else begin
         crossed = sample_i < cfg_i.adc_level;
      end
   end

   assign hit = allow & crossed;

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         allow      <= 1'b0;
         adc_trig_o <= 1'b0;
      end else begin
         adc_trig_o <= hit;
         if (arm_pulse_i) begin
            allow <= 1'b1;
         end else if (hit) begin
            allow <= 1'b0;   // one shot
         end
      end
   end

   a_trig_one_shot: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      adc_trig_o |=> !adc_trig_o);

endmodule

/* hw/capture_sequencer.sv */
`timescale 1ns/1ps

module capture_sequencer (
   input  logic                      ADC_clk_sample,
   input  logic                      reset,
   input  capture_pkg::capture_cfg_t cfg_i,
   input  logic                      arm_i,
   input  logic                      ext_trigger_i,
   input  logic                      adc_trig_i,
   output logic                      arm_pulse_o,
   output logic                      fifo_clear_o,
   output logic                      wr_en_o,
   output logic                      armed_o,
   output logic                      capture_active_o,
   output logic                      capture_done_o
);
   import capture_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_WAIT_INACTIVE,
      S_ARMED,
      S_OFFSET,
      S_CAPTURE,
      S_DONE
   } seq_state_e;

   seq_state_e state;
   count_t     cnt;           // offset, then remaining samples
   logic       arm_q;
   logic       ext_q;         // registered trigger pin
   logic       arm_edge;
   logic       trig_active;

   assign arm_edge = arm_i & ~arm_q;

   // polarity only applies to the pin
   always_comb begin
      if (cfg_i.trig_src == TRIG_ADC) begin
         trig_active = adc_trig_i;
      end else begin
         trig_active = cfg_i.trig_high ? ext_q : ~ext_q;
      end
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         arm_q <= 1'b0;
         ext_q <= 1'b0;
         state <= S_IDLE;
         cnt   <= '0;
      end else begin
         arm_q <= arm_i;
         ext_q <= ext_trigger_i;
         if (arm_edge) begin
            // a new arm restarts from any state
            state <= cfg_i.trig_wait ? S_WAIT_INACTIVE : S_ARMED;
         end else begin
            case (state)
               S_WAIT_INACTIVE: begin
                  if (!trig_active) begin
                     state <= S_ARMED;
                  end
               end
               S_ARMED: begin
                  if (trig_active && cfg_i.offset == '0) begin
                     state <= S_CAPTURE;
                     cnt   <= cfg_i.length;
                  end else if (trig_active) begin
                     state <= S_OFFSET;
                     cnt   <= cfg_i.offset;
                  end
               end
               S_OFFSET: begin
                  if (cnt <= count_t'(1)) begin
                     state <= S_CAPTURE;
                     cnt   <= cfg_i.length;
                  end else begin
                     cnt <= cnt - 1'b1;
                  end
               end
               S_CAPTURE: begin
                  if (cnt <= count_t'(1)) begin
                     state <= S_DONE;   // last write this cycle
                  end else begin
                     cnt <= cnt - 1'b1;
                  end
               end
               default: begin
                  state <= state;       // idle and done hold until the next arm
               end
            endcase
         end
      end
   end

   assign arm_pulse_o      = arm_edge;
   assign fifo_clear_o     = arm_edge;   // old samples dropped on every arm
   assign wr_en_o          = (state == S_CAPTURE);
   assign armed_o          = (state == S_ARMED);
   assign capture_active_o = (state == S_CAPTURE);
   assign capture_done_o   = (state == S_DONE);

   a_wr_in_capture: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      wr_en_o |-> capture_active_o);

endmodule

/* hw/sample_fifo.sv */
`timescale 1ns/1ps
`include "capture_macros.svh"

module sample_fifo (
   input  logic                 ADC_clk_sample,
   input  logic                 reset,
   input  logic                 clear_i,
   input  logic                 wr_en_i,
   input  capture_pkg::sample_t wr_data_i,
   input  logic                 pop_i,
   output capture_pkg::sample_t rd_data_o,
   output logic                 empty_o,
   output logic                 overflow_o
);
   import capture_pkg::*;

   localparam logic [`CAP_FIFO_AW:0] FULL_CNT = `CAP_FIFO_DEPTH;

   sample_t                 mem [`CAP_FIFO_DEPTH];
   logic [`CAP_FIFO_AW-1:0] wr_ptr;
   logic [`CAP_FIFO_AW-1:0] rd_ptr;
   logic [`CAP_FIFO_AW:0]   count;    // one extra bit to tell full from empty
   logic                    full;
   logic                    wr_ok;
   logic                    rd_ok;

   assign full    = (count == FULL_CNT);
   assign empty_o = (count == '0);
   assign wr_ok   = wr_en_i & ~full;    // writes while full are lost
   assign rd_ok   = pop_i & ~empty_o;

   always_ff @(posedge ADC_clk_sample) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset || clear_i) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (wr_en_i && full) begin
            overflow_o <= 1'b1;   // sticky until the next clear
         end
      end
   end

   assign rd_data_o = mem[rd_ptr];   // first word fall-through

   a_no_pop_empty: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      pop_i |-> !empty_o);

endmodule

/* hw/sample_readout.sv */
`timescale 1ns/1ps

module sample_readout (
   input  logic                 ADC_clk_sample,
   input  logic                 reset,
   input  logic                 empty_i,
   input  capture_pkg::sample_t fifo_data_i,
   output logic                 pop_o,
   output logic                 rd_req_o,
   output capture_pkg::sample_t rd_data_o,
   input  logic                 rd_ack_i
);

   typedef enum logic [1:0] {
      R_IDLE,
      R_REQ,        // req high, waiting for ack
      R_RELEASE     // waiting for ack to drop
   } rd_state_e;

   rd_state_e state;

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         state <= R_IDLE;
      end else begin
         case (state)
            R_IDLE: begin
               if (!empty_i && !rd_ack_i) begin
                  state <= R_REQ;
               end
            end
            R_REQ: begin
               if (rd_ack_i) begin
                  state <= R_RELEASE;
               end
            end
            default: begin
               if (!rd_ack_i) begin
                  state <= R_IDLE;
               end
            end
         endcase
      end
   end

   // word held for the whole req phase
   always_ff @(posedge ADC_clk_sample) begin
      if (state == R_IDLE && !empty_i && !rd_ack_i) begin
         rd_data_o <= fifo_data_i;
      end
   end

   assign rd_req_o = (state == R_REQ);
   assign pop_o    = (state == R_REQ) & rd_ack_i & ~empty_i;   // pop as ack is seen

   a_data_stable: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      rd_req_o && !rd_ack_i |=> !rd_req_o || $stable(rd_data_o));

endmodule

/* hw/capture_top.sv */
`timescale 1ns/1ps

module capture_top (
   input  logic                         ADC_clk_sample,
   input  logic                         reset,
   input  capture_pkg::capture_cfg_t    cfg_i,
   input  logic                         arm_i,
   input  capture_pkg::sample_t         adc_data_i,
   input  logic                         ext_trigger_i,
   output capture_pkg::capture_status_t status_o,
   output logic                         rd_req_o,
   output capture_pkg::sample_t         rd_data_o,
   input  logic                         rd_ack_i
);
   import capture_pkg::*;

   sample_t sample;
   sample_t fifo_data;
   logic    adc_trig;
   logic    arm_pulse;
   logic    fifo_clear;
   logic    wr_en;
   logic    armed;
   logic    capture_active;
   logic    capture_done;
   logic    empty;
   logic    overflow;
   logic    pop;

   adc_sample_source u_source (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .cfg_i          (cfg_i),
      .adc_data_i     (adc_data_i),
      .sample_o       (sample)
   );

   adc_level_trigger u_level_trig (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .cfg_i          (cfg_i),
      .sample_i       (sample),
      .arm_pulse_i    (arm_pulse),
      .adc_trig_o     (adc_trig)
   );

   capture_sequencer u_seq (
      .ADC_clk_sample   (ADC_clk_sample),
      .reset            (reset),
      .cfg_i            (cfg_i),
      .arm_i            (arm_i),
      .ext_trigger_i    (ext_trigger_i),
      .adc_trig_i       (adc_trig),
      .arm_pulse_o      (arm_pulse),
      .fifo_clear_o     (fifo_clear),
      .wr_en_o          (wr_en),
      .armed_o          (armed),
      .capture_active_o (capture_active),
      .capture_done_o   (capture_done)
   );

   sample_fifo u_fifo (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .clear_i        (fifo_clear),
      .wr_en_i        (wr_en),
      .wr_data_i      (sample),
      .pop_i          (pop),
      .rd_data_o      (fifo_data),
      .empty_o        (empty),
      .overflow_o     (overflow)
   );

   sample_readout u_readout (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .empty_i        (empty),
      .fifo_data_i    (fifo_data),
      .pop_o          (pop),
      .rd_req_o       (rd_req_o),
      .rd_data_o      (rd_data_o),
      .rd_ack_i       (rd_ack_i)
   );

   assign status_o = '{
      armed:          armed,
      capture_active: capture_active,
      capture_done:   capture_done,
      overflow:       overflow,
      adc_trigger:    adc_trig
   };

endmodule

/* dv/capture_tb.sv */
`timescale 1ns/1ps
`include "capture_macros.svh"

module capture_tb;
   import capture_pkg::*;

   localparam int NUM_TESTS = 7;
   localparam int PHASE     = 8;   // cycles per trigger phase before the capture phase

   typedef struct {
      string        name;
      capture_cfg_t cfg;
      logic [2:0]   ext_seq;     // pin level of phases 0 to 2 with phase 0 in bit 0
      int           ramp;        // adc step per cycle or 0 in test-pattern mode
      sample_t      ramp_base;
      bit           hold_ack;    // host holds back ack until capture_done
      int           exp_count;
      logic         exp_ovf;
      int           first_val;   // -1 when the start value is free
   } test_t;

   // cfg fields in order test_pattern, trig_src, trig_high, trig_wait, adc_level, offset, length
   test_t tests [NUM_TESTS] = '{
      '{"ext_high", '{1'b1, TRIG_EXT, 1'b1, 1'b0, 12'h000, 16'd5, 16'd20},
        3'b100, 0, 12'h000, 1'b0, 20, 1'b0, -1},
      '{"ext_low", '{1'b1, TRIG_EXT, 1'b0, 1'b0, 12'h000, 16'd0, 16'd12},
        3'b011, 0, 12'h000, 1'b0, 12, 1'b0, -1},
      '{"ext_wait", '{1'b1, TRIG_EXT, 1'b1, 1'b1, 12'h000, 16'd3, 16'd16},
        3'b101, 0, 12'h000, 1'b0, 16, 1'b0, -1},
      '{"adc_above", '{1'b0, TRIG_ADC, 1'b0, 1'b0, 12'h900, 16'd0, 16'd24},
        3'b000, 1, 12'h8f0, 1'b0, 24, 1'b0, 'h903},    // crossing at 901 and two cycles to write
      '{"adc_below", '{1'b0, TRIG_ADC, 1'b0, 1'b0, 12'h100, 16'd0, 16'd24},
        3'b000, -1, 12'h110, 1'b0, 24, 1'b0, 'h0fd},
      '{"overflow", '{1'b1, TRIG_EXT, 1'b1, 1'b0, 12'h000, 16'd0, 16'd100},
        3'b100, 0, 12'h000, 1'b1, `CAP_FIFO_DEPTH, 1'b1, -1},
      '{"after_ovf", '{1'b1, TRIG_EXT, 1'b1, 1'b0, 12'h000, 16'd2, 16'd10},
        3'b100, 0, 12'h000, 1'b0, 10, 1'b0, -1}
   };

   logic            ADC_clk_sample;
   logic            reset;
   capture_cfg_t    cfg;
   logic            arm;
   sample_t         adc_data;
   logic            ext_trigger;
   capture_status_t status;
   logic            rd_req;
   sample_t         rd_data;
   logic            rd_ack;

   sample_t     got [$];         // words taken by the host
   bit          hold_ack;
   int          trig_pulses;     // adc_trigger cycles since the last arm
   int          active_cycles;   // capture_active cycles since the last arm
   int unsigned rng = 68;
   int          limit;
   int          cycles;

   capture_top uut (
      .ADC_clk_sample (ADC_clk_sample), .reset (reset), .cfg_i (cfg), .arm_i (arm),
      .adc_data_i (adc_data), .ext_trigger_i (ext_trigger), .status_o (status),
      .rd_req_o (rd_req), .rd_data_o (rd_data), .rd_ack_i (rd_ack)
   );

   initial begin
      ADC_clk_sample = 1'b0;
      forever #10 ADC_clk_sample = ~ADC_clk_sample;
   end

   task automatic tick();
      @(posedge ADC_clk_sample);
      #2;   // drive and look just after the edge
   endtask

   task automatic advance(input int ramp);
      tick();
      adc_data = sample_t'(int'(adc_data) + ramp);
   endtask

   function automatic int unsigned next_random();
      rng ^= rng << 13;
      rng ^= rng >> 17;
      rng ^= rng << 5;
      return rng;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1, "run stopped");
   endtask

   task automatic check_sample(input string name, input sample_t exp, input sample_t act);
      if (act !== exp) begin
         abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_status(input string name, input capture_status_t exp,
                               input capture_status_t act);
      if (act !== exp) begin
         abort_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         abort_run($sformatf("CHECK FAILED %s expected %0d actual %0d", name, exp, act));
      end
   endtask

   task automatic run_test(input test_t t);
      capture_status_t exp_st;
      int              ph;
      int              i;
      arm         = 1'b0;
      cfg         = t.cfg;
      adc_data    = t.ramp_base;
      ext_trigger = t.ext_seq[0];
      hold_ack    = t.hold_ack;
      got.delete();
      repeat (4) tick();
      arm           = 1'b1;   // edge taken at the next clock
      trig_pulses   = 0;
      active_cycles = 0;
      for (ph = 0; ph < 2; ph++) begin
         ext_trigger = t.ext_seq[ph];
         repeat (PHASE) advance(t.ramp);
         exp_st       = '0;
         exp_st.armed = (ph == 1) || !t.cfg.trig_wait;
         check_status($sformatf("%s_phase%0d", t.name, ph), exp_st, status);
         check_count($sformatf("%s_phase%0d_reads", t.name, ph), 0, got.size());
      end
      ext_trigger = t.ext_seq[2];
      while (!status.capture_done) advance(t.ramp);
      hold_ack = 1'b0;
      while (got.size() < t.exp_count) tick();
      repeat (12) tick();   // room for a stray extra word
      exp_st              = '0;
      exp_st.capture_done = 1'b1;
      exp_st.overflow     = t.exp_ovf;
      check_status({t.name, "_end"}, exp_st, status);
      check_count({t.name, "_reads"}, t.exp_count, got.size());
      check_count({t.name, "_adc_triggers"}, (t.cfg.trig_src == TRIG_ADC) ? 1 : 0, trig_pulses);
      check_count({t.name, "_active_cycles"}, int'(t.cfg.length), active_cycles);
      if (t.first_val >= 0) begin
         check_sample({t.name, "_first"}, sample_t'(t.first_val), got[0]);
      end
      for (i = 1; i < got.size(); i++) begin
         check_sample($sformatf("%s_word%0d", t.name, i),
                      sample_t'(int'(got[i-1]) + ((t.ramp == 0) ? 1 : t.ramp)), got[i]);
      end
      // level msb picks above or below
      for (i = 0; i < got.size() && t.cfg.trig_src == TRIG_ADC; i++) begin
         if (t.cfg.adc_level[`CAP_SAMPLE_W-1] ? (got[i] <= t.cfg.adc_level)
                                              : (got[i] >= t.cfg.adc_level)) begin
            abort_run($sformatf("%s: word %h is on the wrong side of level %h",
                                t.name, got[i], t.cfg.adc_level));
         end
      end
   endtask

   // host side of the four-phase handshake
   initial begin : host_model
      int unsigned delay;
      forever begin
         tick();
         if (rd_req && !hold_ack) begin
            delay = next_random() % 3;
            repeat (delay) tick();
            got.push_back(rd_data);
            rd_ack = 1'b1;
            while (rd_req) tick();
            rd_ack = 1'b0;
         end
      end
   end

   // watches the handshake and the status on pre-edge values
   initial begin : handshake_monitor
      logic    req_q;
      logic    ack_q;
      sample_t data_q;
      req_q = 1'b0;
      ack_q = 1'b0;
      forever begin
         @(posedge ADC_clk_sample);
         if (req_q && !ack_q && rd_req) begin
            check_sample("handshake_hold", data_q, rd_data);
         end
         if (status.adc_trigger === 1'b1) begin
            trig_pulses++;
         end
         if (status.capture_active === 1'b1) begin
            active_cycles++;
         end
         req_q  = rd_req;
         ack_q  = rd_ack;
         data_q = rd_data;
      end
   end

   initial begin : watchdog
      wait (limit > 0);
      cycles = 0;
      while (cycles < limit) begin
         @(posedge ADC_clk_sample);
         cycles++;
      end
      abort_run($sformatf("timeout, the tests did not finish within %0d cycles", limit));
   end

   initial begin : main
      int n;
      int budget;
      reset         = 1'b1;
      cfg           = '0;
      arm           = 1'b0;
      adc_data      = '0;
      ext_trigger   = 1'b0;
      rd_ack        = 1'b0;
      hold_ack      = 1'b0;
      trig_pulses   = 0;
      active_cycles = 0;
      budget        = 20;
      for (n = 0; n < NUM_TESTS; n++) begin
         budget += tests[n].cfg.offset + 5 * tests[n].cfg.length + 200;
      end
      limit = budget;
      repeat (5) tick();
      reset = 1'b0;
      tick();
      check_status("after_reset", '0, status);
      check_count("after_reset_req", 0, rd_req);
      for (n = 0; n < NUM_TESTS; n++) begin
         run_test(tests[n]);
      end
      $display("No errors");
      $finish;
   end

endmodule

/* project.f */
+incdir+hw
hw/capture_pkg.sv
hw/adc_sample_source.sv
hw/adc_level_trigger.sv
hw/capture_sequencer.sv
hw/sample_fifo.sv
hw/sample_readout.sv
hw/capture_top.sv
dv/capture_tb.sv

/* Bender.yml */
package:
  name: capture_frontend

sources:
  - include_dirs:
      - hw
    files:
      - hw/capture_pkg.sv
      - hw/adc_sample_source.sv
      - hw/adc_level_trigger.sv
      - hw/capture_sequencer.sv
      - hw/sample_fifo.sv
      - hw/sample_readout.sv
      - hw/capture_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/capture_tb.sv
